// File: hw/fetch_mux_pkg.sv
package fetch_mux_pkg;

	// ========================================================================
	// Basic sizes and addresses
	// ========================================================================

	// Every instruction is one 32-bit word
	localparam int INS_BYTES = 4;

	// Byte address of an instruction
	typedef logic [31:0] pc_t;

	// ========================================================================
	// Instruction encoding
	// ========================================================================

	// Only the opcodes that the fetch mux has to recognize are named here
	typedef enum logic [6:0] {
		OP_NOP  = 7'h0B,
		OP_BSR  = 7'h20,
		OP_JSR  = 7'h21,
		OP_JSRR = 7'h22,
		OP_RTD  = 7'h23
	} opcode_e;

	// For BSR the disp field is a signed word displacement from the PC
	// For JSR it is an absolute word address
	// A zero rt means no link register, so the instruction is a plain jump
	typedef struct packed {
		logic [21:0] disp;
		logic [2:0]  rt;
		opcode_e     opcode;
	} instr_t;

	localparam instr_t NOP_INS = '{
		disp:   22'd0,
		rt:     3'd0,
		opcode: OP_NOP
	};

	// ========================================================================
	// Pipeline records
	// ========================================================================

	// One instruction slot as it leaves the mux stage
	typedef struct packed {
		logic       v;
		logic       hwi;
		logic [2:0] hwi_level;
		pc_t        pc;
		instr_t     ins;
	} slot_t;

	// Result of the early control-flow scan over one group of slots
	typedef struct packed {
		logic do_bsr;
		logic do_call;
		logic do_ret;
		pc_t  bsr_tgt;
		pc_t  ret_pc;
	} flow_t;

endpackage

// File: hw/line_aligner.sv
`timescale 1ns/1ps

module line_aligner import fetch_mux_pkg::*; #(
	parameter int LINE_INS = 8,
	parameter int SLOTS = 4
) (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic [LINE_INS*32-1:0] line_i,
	input  pc_t                    pc_i,
	input  logic                   advance_fet_i,
	input  logic                   nmi_i,
	input  logic                   irqf_i,
	input  logic [2:0]             irq_level_i,
	input  logic                   stomp_i,
	output slot_t                  raw_slot_o [SLOTS]
);

	// Byte offset bits below the word index, and the word index width
	localparam int OFS_W = $clog2(INS_BYTES);
	localparam int IDX_W = $clog2(LINE_INS);

	logic [IDX_W-1:0] word_idx;
	logic [2*LINE_INS*32-1:0] padded;
	instr_t [LINE_INS-1:0] aligned;
	instr_t [LINE_INS-1:0] prev_aligned;
	pc_t prev_pc;
	logic redundant;
	logic hw_irq;

	// ========================================================================
	// Line alignment
	// ========================================================================

	assign word_idx = pc_i[OFS_W +: IDX_W];

	// NOPs are stacked above the line so that the words shifted in from the
	// top end of the line are already NOP instructions
	assign padded = {{LINE_INS{NOP_INS}}, line_i} >> (word_idx * 32);
	assign aligned = padded[LINE_INS*32-1:0];

	// ========================================================================
	// Redundant group detection
	// ========================================================================

	// The fetch unit may present the same group again while it waits, and
	// that group must not be issued twice
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc <= '0;
			prev_aligned <= '0;
		end else if (advance_fet_i) begin
			prev_pc <= pc_i;
			prev_aligned <= aligned;
		end
	end

	assign redundant = (pc_i == prev_pc) && (aligned == prev_aligned);

	// ========================================================================
	// Raw slot construction
	// ========================================================================

	// A pending NMI or IRQ takes the place of the whole group
	assign hw_irq = nmi_i || irqf_i;

	always_comb begin
		for (int i = 0; i < SLOTS; i++) begin
			raw_slot_o[i].v = !hw_irq && !stomp_i;
			raw_slot_o[i].hwi = hw_irq;
			raw_slot_o[i].hwi_level = irq_level_i;
			// Slots hold consecutive words
			raw_slot_o[i].pc = pc_i + pc_t'(i * INS_BYTES);
			raw_slot_o[i].ins = redundant ? NOP_INS : aligned[i];
		end
	end

	// The first slot always carries the word that the fetch PC points at
	a_slot0_word: assert property (@(posedge clk) disable iff (rst_i)
		!redundant |-> raw_slot_o[0].ins == instr_t'(line_i[word_idx*32 +: 32]))
		else $error("line_aligner: slot 0 is not the word at the fetch PC");

endmodule

// File: hw/slot_stage.sv
`timescale 1ns/1ps

module slot_stage import fetch_mux_pkg::*; (
	input  logic  clk,
	input  logic  rst_i,
	input  logic  en_i,
	input  logic  branchmiss_i,
	input  pc_t   misspc_i,
	input  slot_t raw_slot_i,
	output slot_t slot_o
);

	localparam slot_t EMPTY_SLOT = '{
		v:         1'b0,
		hwi:       1'b0,
		hwi_level: 3'd0,
		pc:        '0,
		ins:       NOP_INS
	};

	logic kill;
	slot_t next_slot;

	// Instructions ahead of the miss PC belong to the wrong path
	assign kill = branchmiss_i && (misspc_i > raw_slot_i.pc);

	always_comb begin
		next_slot = raw_slot_i;
		if (kill) begin
			next_slot.ins = NOP_INS;
			next_slot.v = 1'b0;
		end
	end

	// The enable is the only way to hold the stage
	always_ff @(posedge clk) begin
		if (rst_i)
			slot_o <= EMPTY_SLOT;
		else if (en_i)
			slot_o <= next_slot;
	end

	// A killed slot must never reach decode as valid
	a_kill_invalid: assert property (@(posedge clk) disable iff (rst_i)
		(en_i && kill) |=> !slot_o.v)
		else $error("slot_stage: killed slot registered as valid");

endmodule

// File: hw/flow_detect.sv
`timescale 1ns/1ps

module flow_detect import fetch_mux_pkg::*; #(
	parameter int SLOTS = 4
) (
	input  slot_t slot_i [SLOTS],
	input  logic  stomp_i,
	output flow_t flow_o
);

	// BSR and JSR with any rt, so both branches and calls of that kind
	logic [SLOTS-1:0] is_bsr;
	logic [SLOTS-1:0] is_jsr;
	logic [SLOTS-1:0] is_call;
	logic [SLOTS-1:0] is_ret;
	logic [SLOTS-1:0] is_flow;
	pc_t disp_bytes [SLOTS];
	logic found;

	// ========================================================================
	// Per-slot classification
	// ========================================================================

	always_comb begin
		for (int i = 0; i < SLOTS; i++) begin
			is_bsr[i] = slot_i[i].ins.opcode == OP_BSR;
			is_jsr[i] = slot_i[i].ins.opcode == OP_JSR;
			is_ret[i] = slot_i[i].ins.opcode == OP_RTD;
			// JSRR without a link register is a register jump and is left to
			// the later stages
			is_call[i] = (is_bsr[i] || is_jsr[i] || slot_i[i].ins.opcode == OP_JSRR)
				&& (slot_i[i].ins.rt != 3'd0);
			is_flow[i] = is_bsr[i] || is_jsr[i] || is_call[i] || is_ret[i];
			// Word displacement scaled to bytes
			disp_bytes[i] = {{8{slot_i[i].ins.disp[21]}}, slot_i[i].ins.disp, 2'b00};
		end
	end

	// ========================================================================
	// First flow change in the group
	// ========================================================================

	// Only the earliest control transfer matters since everything after it
	// is off the path anyway
	always_comb begin
		found = 1'b0;
		flow_o = '0;
		for (int i = 0; i < SLOTS; i++) begin
			if (!found && is_flow[i]) begin
				found = 1'b1;
				flow_o.do_bsr = is_bsr[i] || is_jsr[i];
				flow_o.do_call = is_call[i];
				flow_o.do_ret = is_ret[i];
				if (is_bsr[i])
					flow_o.bsr_tgt = slot_i[i].pc + disp_bytes[i];
				else if (is_jsr[i])
					flow_o.bsr_tgt = disp_bytes[i];
				if (is_call[i])
					flow_o.ret_pc = slot_i[i].pc + pc_t'(INS_BYTES);
			end
		end
		// A stomped group redirects nothing, targets are don't care then
		if (stomp_i) begin
			flow_o.do_bsr = 1'b0;
			flow_o.do_call = 1'b0;
			flow_o.do_ret = 1'b0;
		end
	end

	// The return stack and the branch target path cannot both be steered
	always_comb begin
		assert (!(flow_o.do_bsr && flow_o.do_ret))
			else $error("flow_detect: branch and return flagged together");
	end

endmodule

// File: hw/fetch_mux_top.sv
`timescale 1ns/1ps

module fetch_mux_top import fetch_mux_pkg::*; #(
	parameter int LINE_INS = 8,
	parameter int SLOTS = 4
) (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic [LINE_INS*32-1:0] line_i,
	input  pc_t                    pc_i,
	input  logic                   advance_fet_i,
	input  logic                   en_i,
	input  logic                   nmi_i,
	input  logic                   irqf_i,
	input  logic [2:0]             irq_level_i,
	input  logic                   stomp_i,
	input  logic                   branchmiss_i,
	input  pc_t                    misspc_i,
	output slot_t                  slot_o [SLOTS],
	output flow_t                  flow_o,
	output logic                   nop_o
);

	slot_t raw_slot [SLOTS];
	logic [SLOTS-1:0] slot_valid;

	// ========================================================================
	// Alignment and slot extraction
	// ========================================================================

	line_aligner #(
		.LINE_INS (LINE_INS),
		.SLOTS    (SLOTS)
	) u_aligner (
		.clk           (clk),
		.rst_i         (rst_i),
		.line_i        (line_i),
		.pc_i          (pc_i),
		.advance_fet_i (advance_fet_i),
		.nmi_i         (nmi_i),
		.irqf_i        (irqf_i),
		.irq_level_i   (irq_level_i),
		.stomp_i       (stomp_i),
		.raw_slot_o    (raw_slot)
	);

	// One register stage per slot
	for (genvar i = 0; i < SLOTS; i++) begin : g_slot
		slot_stage u_stage (
			.clk          (clk),
			.rst_i        (rst_i),
			.en_i         (en_i),
			.branchmiss_i (branchmiss_i),
			.misspc_i     (misspc_i),
			.raw_slot_i   (raw_slot[i]),
			.slot_o       (slot_o[i])
		);

		assign slot_valid[i] = slot_o[i].v;
	end

	// ========================================================================
	// Control flow scan and NOP flag
	// ========================================================================

	flow_detect #(
		.SLOTS (SLOTS)
	) u_flow (
		.slot_i  (slot_o),
		.stomp_i (stomp_i),
		.flow_o  (flow_o)
	);

	// nop_o lines up with the group registered on the same enabled edge
	always_ff @(posedge clk) begin
		if (rst_i)
			nop_o <= 1'b0;
		else if (en_i)
			nop_o <= stomp_i;
	end

	// A stomped group must come out of every slot stage as invalid
	a_nop_no_valid: assert property (@(posedge clk) disable iff (rst_i)
		nop_o |-> (slot_valid == '0))
		else $error("fetch_mux_top: valid slot issued with nop_o set");

endmodule

// File: test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Whole groups and lines as packed arrays so that functions can return them
typedef slot_t [SLOTS-1:0] slot_group_t;
typedef instr_t [LINE_INS-1:0] line_words_t;

localparam slot_t EMPTY_SLOT = '{
	v:         1'b0,
	hwi:       1'b0,
	hwi_level: 3'd0,
	pc:        '0,
	ins:       NOP_INS
};

// Word k of the line counted from the instruction at the fetch PC
function automatic instr_t line_word(logic [LINE_INS*32-1:0] line, pc_t pc, int k);
	int idx;
	idx = int'((pc / INS_BYTES) % LINE_INS) + k;
	if (idx >= LINE_INS)
		return NOP_INS;
	return instr_t'(line[idx*32 +: 32]);
endfunction

function automatic line_words_t aligned_line(logic [LINE_INS*32-1:0] line, pc_t pc);
	line_words_t words;
	for (int k = 0; k < LINE_INS; k++)
		words[k] = line_word(line, pc, k);
	return words;
endfunction

function automatic slot_group_t expected_slots(
	logic [LINE_INS*32-1:0] line, pc_t pc, pc_t prev_pc, line_words_t prev_words,
	logic nmi, logic irqf, logic [2:0] level, logic stomp,
	logic bmiss, pc_t misspc
);
	slot_group_t grp;
	logic repeat_group;
	repeat_group = (pc == prev_pc) && (aligned_line(line, pc) == prev_words);
	for (int i = 0; i < SLOTS; i++) begin
		grp[i].v = !(nmi || irqf || stomp);
		grp[i].hwi = nmi || irqf;
		grp[i].hwi_level = level;
		grp[i].pc = pc + pc_t'(i * INS_BYTES);
		grp[i].ins = repeat_group ? NOP_INS : line_word(line, pc, i);
		// Wrong-path slots sit below the miss PC
		if (bmiss && misspc > grp[i].pc) begin
			grp[i].ins = NOP_INS;
			grp[i].v = 1'b0;
		end
	end
	return grp;
endfunction

function automatic flow_t expected_flow(slot_group_t grp, logic stomp);
	flow_t f;
	slot_t s;
	int first;
	logic link;
	pc_t offset;
	f = '0;
	first = -1;
	// Walk downwards so the lowest transferring slot is the one left in first
	for (int i = SLOTS - 1; i >= 0; i--) begin
		link = grp[i].ins.rt != 3'd0;
		if (grp[i].ins.opcode inside {OP_BSR, OP_JSR, OP_RTD})
			first = i;
		else if (grp[i].ins.opcode == OP_JSRR && link)
			first = i;
	end
	if (first >= 0) begin
		s = grp[first];
		link = s.ins.rt != 3'd0;
		offset = pc_t'(int'($signed(s.ins.disp)) * 4);
		f.do_bsr = s.ins.opcode inside {OP_BSR, OP_JSR};
		f.do_ret = s.ins.opcode == OP_RTD;
		f.do_call = link && !f.do_ret;
		if (s.ins.opcode == OP_BSR)
			f.bsr_tgt = s.pc + offset;
		else if (s.ins.opcode == OP_JSR)
			f.bsr_tgt = offset;
		if (f.do_call)
			f.ret_pc = s.pc + pc_t'(INS_BYTES);
	end
	if (stomp) begin
		f.do_bsr = 1'b0;
		f.do_call = 1'b0;
		f.do_ret = 1'b0;
	end
	return f;
endfunction

`endif

// File: test/tb_fetch_mux.sv
`timescale 1ns/1ps

module tb_fetch_mux import fetch_mux_pkg::*; ();

	localparam int LINE_INS = 8;
	localparam int SLOTS = 4;
	localparam int CLK_NS = 40;
	localparam int N_ALIGN = 60;
	localparam int N_FLOW = 60;
	// Directed vectors, resets and the drain at the end, rounded up
	localparam int N_VECTORS = N_ALIGN + N_FLOW + 70;
	localparam int WATCHDOG_NS = (N_VECTORS + 20) * CLK_NS;

	`include "tb_ref_model.svh"

	logic clk;
	logic rst_i;
	logic [LINE_INS*32-1:0] line_i;
	pc_t pc_i;
	logic advance_fet_i;
	logic en_i;
	logic nmi_i;
	logic irqf_i;
	logic [2:0] irq_level_i;
	logic stomp_i;
	logic branchmiss_i;
	pc_t misspc_i;
	slot_t slot_o [SLOTS];
	flow_t flow_o;
	logic nop_o;

	integer seed;
	int fail_count = 0;
	logic model_ready = 1'b0;
	slot_group_t exp_slots;
	logic exp_nop;
	pc_t prev_pc;
	line_words_t prev_words;

	fetch_mux_top #(
		.LINE_INS (LINE_INS),
		.SLOTS    (SLOTS)
	) u_dut (
		.clk           (clk),
		.rst_i         (rst_i),
		.line_i        (line_i),
		.pc_i          (pc_i),
		.advance_fet_i (advance_fet_i),
		.en_i          (en_i),
		.nmi_i         (nmi_i),
		.irqf_i        (irqf_i),
		.irq_level_i   (irq_level_i),
		.stomp_i       (stomp_i),
		.branchmiss_i  (branchmiss_i),
		.misspc_i      (misspc_i),
		.slot_o        (slot_o),
		.flow_o        (flow_o),
		.nop_o         (nop_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// ========================================================================
	// Reference tracking and comparison
	// ========================================================================

	// Inputs are read here before the stimulus updates of the same edge land
	always @(posedge clk) begin
		if (rst_i) begin
			exp_slots = {SLOTS{EMPTY_SLOT}};
			exp_nop = 1'b0;
			prev_pc = '0;
			prev_words = '0;
			model_ready = 1'b1;
		end else begin
			if (en_i) begin
				exp_slots = expected_slots(line_i, pc_i, prev_pc, prev_words, nmi_i,
					irqf_i, irq_level_i, stomp_i, branchmiss_i, misspc_i);
				exp_nop = stomp_i;
			end
			if (advance_fet_i) begin
				prev_pc = pc_i;
				prev_words = aligned_line(line_i, pc_i);
			end
		end
	end

	// The flow result follows the live stomp input, so it is rebuilt here
	always @(negedge clk) begin
		if (model_ready) begin
			for (int i = 0; i < SLOTS; i++)
				check_slot($sformatf("slot_o[%0d]", i), slot_o[i], exp_slots[i]);
			check_flow("flow_o", flow_o, expected_flow(exp_slots, stomp_i));
			check_bit("nop_o", nop_o, exp_nop);
		end
	end

	task automatic report_failure();
		fail_count++;
		$display("Test failures found");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic check_slot(input string name, input slot_t got, input slot_t exp);
		if (got !== exp) begin
			$display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_flow(input string name, input flow_t got, input flow_t exp);
		if (got !== exp) begin
			$display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL time %0t %s got %b expected %b", $time, name, got, exp);
			report_failure();
		end
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	function automatic pc_t random_pc();
		return pc_t'($random(seed)) & ~pc_t'(3);
	endfunction

	function automatic logic [LINE_INS*32-1:0] random_line();
		logic [LINE_INS*32-1:0] line;
		for (int k = 0; k < LINE_INS; k++)
			line[k*32 +: 32] = $random(seed);
		return line;
	endfunction

	// Mix of transfer opcodes, about half of them with a link register
	function automatic logic [LINE_INS*32-1:0] random_flow_line();
		logic [LINE_INS*32-1:0] line;
		instr_t ins;
		int sel;
		for (int k = 0; k < LINE_INS; k++) begin
			sel = int'($unsigned($random(seed)) % 6);
			case (sel)
				0: ins.opcode = OP_BSR;
				1: ins.opcode = OP_JSR;
				2: ins.opcode = OP_JSRR;
				3: ins.opcode = OP_RTD;
				default: ins.opcode = OP_NOP;
			endcase
			ins.rt = ($random(seed) & 1) ? 3'($random(seed)) : 3'd0;
			ins.disp = 22'($random(seed));
			line[k*32 +: 32] = ins;
		end
		return line;
	endfunction

	// New group on the next edge with every side input back at its idle value
	task automatic drive_group(input logic [LINE_INS*32-1:0] line, input pc_t pc);
		@(posedge clk);
		line_i <= line;
		pc_i <= pc;
		advance_fet_i <= 1'b1;
		en_i <= 1'b1;
		nmi_i <= 1'b0;
		irqf_i <= 1'b0;
		irq_level_i <= 3'd0;
		stomp_i <= 1'b0;
		branchmiss_i <= 1'b0;
		misspc_i <= '0;
	endtask

	initial begin
		logic [LINE_INS*32-1:0] line;
		pc_t pc;
		seed = 32'hd9609a89;
		rst_i = 1'b1;
		line_i = '0;
		pc_i = '0;
		advance_fet_i = 1'b1;
		en_i = 1'b1;
		nmi_i = 1'b0;
		irqf_i = 1'b0;
		irq_level_i = 3'd0;
		stomp_i = 1'b0;
		branchmiss_i = 1'b0;
		misspc_i = '0;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;

		repeat (N_ALIGN) drive_group(random_line(), random_pc());

		// Same group twice, then a moved PC over the same line
		for (int r = 0; r < 4; r++) begin
			line = random_line();
			pc = random_pc();
			drive_group(line, pc);
			drive_group(line, pc);
			drive_group(line, pc + pc_t'(INS_BYTES));
		end

		for (int r = 0; r < 4; r++) begin
			drive_group(random_line(), random_pc());
			nmi_i <= 1'b1;
			irq_level_i <= 3'($random(seed));
			drive_group(random_line(), random_pc());
			irqf_i <= 1'b1;
			irq_level_i <= 3'($random(seed));
			drive_group(random_line(), random_pc());
			stomp_i <= 1'b1;
		end

		for (int k = 0; k <= SLOTS; k++) begin
			pc = random_pc();
			drive_group(random_line(), pc);
			branchmiss_i <= 1'b1;
			misspc_i <= pc + pc_t'(k * INS_BYTES);
		end

		repeat (N_FLOW) drive_group(random_flow_line(), random_pc());
		repeat (6) begin
			drive_group(random_flow_line(), random_pc());
			stomp_i <= 1'b1;
		end

		// Outputs must hold while the enable is low
		drive_group(random_flow_line(), random_pc());
		stomp_i <= 1'b1;
		repeat (3) begin
			drive_group(random_flow_line(), random_pc());
			en_i <= 1'b0;
			stomp_i <= 1'($random(seed));
		end

		// A group seen without advance does not replace the previous one
		line = random_line();
		pc = random_pc();
		drive_group(line, pc);
		drive_group(random_line(), random_pc());
		advance_fet_i <= 1'b0;
		drive_group(line, pc);

		drive_group(random_line(), random_pc());
		rst_i <= 1'b1;
		repeat (2) drive_group(random_line(), random_pc());
		rst_i <= 1'b0;
		repeat (4) drive_group(random_flow_line(), random_pc());

		// Stop on a rising edge so that the last compares at the falling edges are done
		repeat (3) @(posedge clk);
		if (fail_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the stimulus did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failures found");
		$fatal(1, "Simulation stopped by the watchdog");
	end

endmodule

// File: build.f
+incdir+test
hw/fetch_mux_pkg.sv
hw/line_aligner.sv
hw/slot_stage.sv
hw/flow_detect.sv
hw/fetch_mux_top.sv
test/tb_fetch_mux.sv

// File: Makefile
TOP = tb_fetch_mux

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF 'All tests passed!'

clean:
	rm -rf obj_dir
